//--- files.f
common/isa_pkg.sv
common/bus_pkg.sv
rtl/bus_cycle_ctrl.sv
rtl/pc_unit.sv
rtl/int_unit.sv
rtl/exec_fsm.sv
rtl/cpu_top.sv
dv/cpu_assertions.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: gb_cpu_core

sources:
  - files:
      - common/isa_pkg.sv
      - common/bus_pkg.sv
      - rtl/bus_cycle_ctrl.sv
      - rtl/pc_unit.sv
      - rtl/int_unit.sv
      - rtl/exec_fsm.sv
      - rtl/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_assertions.sv
      - dv/cpu_tb.sv

//--- dv/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb
    import isa_pkg::*;
    import bus_pkg::*;
();

    localparam int     CLK_PERIOD   = 20;
    localparam int     CYCLE_BUDGET = 450;  // Machine cycles over all tests
    localparam longint TIMEOUT_NS   = 2 * CYCLE_BUDGET * 4 * CLK_PERIOD;
    localparam int     SEED         = 32'hd6cc;

    // Model modes
    localparam int M_FETCH   = 0;
    localparam int M_PUSH_HI = 1;
    localparam int M_PUSH_LO = 2;
    localparam int M_HALT    = 3;
    localparam int M_STOP    = 4;

    logic      clk;
    logic      rst;
    data_t     din;
    int_bits_t int_en;
    int_bits_t int_flags_in;
    data_t     key_in;
    logic      phi;
    logic      rd;
    logic      wr;
    logic      done;
    ct_e       ct;
    addr_t     a;
    data_t     dout;
    int_bits_t int_flags_out;

    data_t     mem [0:65535];
    int_bits_t flag_capt;  // IF register as seen at the last edge
    int_bits_t flag_set;   // Bits raised by the test
    int        err_cnt;
    int        recorded;

    logic [1:0] rec_kind[$];
    addr_t      rec_addr[$];
    data_t      rec_data[$];
    int_bits_t  rec_flags[$];

    int    m_mode;
    addr_t m_pc;
    addr_t m_sp;
    addr_t m_ret;
    addr_t m_vec;
    logic  m_ime;

    cpu_top u_cpu_top (
        .clk           (clk),
        .rst           (rst),
        .din           (din),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .key_in        (key_in),
        .phi           (phi),
        .rd            (rd),
        .wr            (wr),
        .done          (done),
        .ct            (ct),
        .a             (a),
        .dout          (dout),
        .int_flags_out (int_flags_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign din = rd ? mem[a] : 8'h00;  // Memory answers combinationally

    ////////////////////////////////////////
    // IF register and bus monitor
    ////////////////////////////////////////
    always @(posedge clk) begin
        flag_capt <= rst ? '0 : int_flags_out;
    end

    always @(negedge clk) begin
        int_flags_in <= flag_capt | flag_set;
        flag_set     <= '0;
    end

    always @(posedge clk) begin
        // phi high through T1 and T2, low in T3
        if (!rst && ct == T2) check_value("phi", phi, 1);
        if (!rst && ct == T3) check_value("phi", phi, 0);
        if (!rst && ct == T2 && rd) begin
            rec_kind.push_back(2'd1);
            rec_addr.push_back(a);
            rec_data.push_back(dout);
            rec_flags.push_back(int_flags_in);
            recorded++;
        end
        if (!rst && ct == T3 && wr) begin
            rec_kind.push_back(2'd2);
            rec_addr.push_back(a);
            rec_data.push_back(dout);
            rec_flags.push_back(int_flags_in);
            mem[a] <= dout;
            recorded++;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic addr_t int_vector(input int_bits_t pend);
        addr_t v;
        v = 16'h0000;
        for (int i = INT_W - 1; i >= 0; i--) begin
            if (pend[i]) v = INT_VEC_BASE + INT_VEC_STEP * addr_t'(i);
        end
        return v;
    endfunction

    // Next bus cycle as {kind, address, data}, kind 1 fetch, 2 write
    function automatic logic [25:0] expected_next(input int mode, input addr_t pc,
                                                  input addr_t ret, input addr_t sp,
                                                  input logic ime);
        case (mode)
            M_PUSH_HI: return {2'd2, addr_t'(sp - 16'd1), ret[15:8]};
            M_PUSH_LO: return {2'd2, addr_t'(sp - 16'd1), ret[7:0]};
            M_HALT:    return ime ? {2'd2, addr_t'(sp - 16'd1), pc[15:8]} : {2'd1, pc, 8'h00};
            default:   return {2'd1, pc, 8'h00};
        endcase
    endfunction

    task automatic advance_model(input int_bits_t flags);
        int_bits_t pend;
        data_t     op;
        pend = flags & int_en;
        if (m_mode == M_PUSH_HI) begin
            m_sp   = m_sp - 16'd1;
            m_mode = M_PUSH_LO;
        end else if (m_mode == M_PUSH_LO) begin
            m_sp   = m_sp - 16'd1;
            m_pc   = m_vec;
            m_ime  = 1'b0;
            m_mode = M_FETCH;
        end else if (m_mode == M_HALT && m_ime) begin
            m_ret  = m_pc;   // High byte already pushed
            m_vec  = int_vector(pend);
            m_sp   = m_sp - 16'd1;
            m_mode = M_PUSH_LO;
        end else if (m_ime && pend != '0) begin
            m_ret  = m_pc;   // Discarded fetch goes on the stack
            m_vec  = int_vector(pend);
            m_mode = M_PUSH_HI;
        end else begin
            op     = mem[m_pc];
            m_pc   = m_pc + 16'd1;
            m_mode = M_FETCH;
            if (op == OP_EI) m_ime = 1'b1;
            if (op == OP_DI) m_ime = 1'b0;
            if (op == OP_HALT) m_mode = M_HALT;
            if (op == OP_STOP) m_mode = M_STOP;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin : compare_loop
        logic [1:0]  kind;
        addr_t       addr;
        data_t       data;
        int_bits_t   flags;
        logic [25:0] exp;
        forever begin
            wait (rec_kind.size() != 0);
            kind  = rec_kind.pop_front();
            addr  = rec_addr.pop_front();
            data  = rec_data.pop_front();
            flags = rec_flags.pop_front();
            exp   = expected_next(m_mode, m_pc, m_ret, m_sp, m_ime);
            check_value("bus cycle kind", kind, exp[25:24]);
            check_value("a", addr, exp[23:8]);
            check_value("dout", data, exp[7:0]);
            advance_model(flags);
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    function automatic data_t filler_byte();
        data_t b;
        b = data_t'($urandom);
        if (b == OP_HALT || b == OP_STOP || b == OP_DI || b == OP_EI) b = 8'h00;
        return b;
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) mem[i] = filler_byte();
    endtask

    task automatic reset_dut(input int_bits_t en, input data_t key);
        wait (rec_kind.size() == 0);
        @(negedge clk);
        rst    = 1'b1;
        int_en = en;
        key_in = key;
        repeat (3) @(negedge clk);
        check_value("rd", rd, 0);
        check_value("wr", wr, 0);
        check_value("done", done, 0);
        check_value("dout", dout, 0);
        check_value("phi", phi, 1);
        m_mode = M_FETCH;
        m_pc   = PC_RESET;
        m_sp   = SP_RESET;
        m_ime  = 1'b0;
        rst    = 1'b0;
    endtask

    task automatic raise_flags(input int_bits_t bits);
        repeat ($urandom_range(3)) @(posedge clk);  // Random offset
        @(posedge clk);
        flag_set = bits;
    endtask

    task automatic wait_fetch(input addr_t addr);
        wait (m_mode == M_FETCH && m_pc == addr);
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        int_en       = '0;
        key_in       = '0;
        int_flags_in = '0;
        flag_capt    = '0;
        flag_set     = '0;
        err_cnt      = 0;
        recorded     = 0;

        fill_memory();  // Sequential fetch across the high byte carry
        reset_dut(5'b00000, 8'h00);
        wait_fetch(16'h0101);

        fill_memory();  // Dispatch, flag 1 beats flag 3
        mem[0] = OP_EI;
        reset_dut(5'b01010, 8'h00);
        wait_fetch(16'h0003);
        raise_flags(5'b01010);
        wait_fetch(16'h0049);
        check_value("int_flags_in", int_flags_in, 5'b01000);
        wait_fetch(16'h0059);   // IME now clear, bit 3 ignored

        fill_memory();  // EI then DI, later flag stays pending
        mem[0] = OP_EI;
        mem[1] = OP_DI;
        reset_dut(5'b00010, 8'h00);
        wait_fetch(16'h0003);
        raise_flags(5'b00010);
        wait_fetch(16'h0020);

        fill_memory();  // HALT without IME
        mem[4] = OP_HALT;
        reset_dut(5'b00100, 8'h00);
        wait (done === 1'b1);
        begin : halt_idle
            int n;
            n = recorded;
            repeat (32) @(negedge clk);
            check_value("bus strobes while halted", recorded, n);
        end
        raise_flags(5'b00100);
        wait (done === 1'b0);
        wait_fetch(16'h000A);

        fill_memory();  // HALT with IME
        mem[0] = OP_EI;
        mem[3] = OP_HALT;
        reset_dut(5'b00001, 8'h00);
        wait (done === 1'b1);
        raise_flags(5'b00001);
        wait_fetch(16'h0041);
        check_value("int_flags_in", int_flags_in, 5'b00000);

        fill_memory();  // STOP woken by a key
        mem[2] = OP_STOP;
        reset_dut(5'b00000, 8'h00);
        wait (done === 1'b1);
        repeat (1 + $urandom_range(8)) @(negedge clk);
        key_in = 8'h01;
        wait_fetch(16'h0006);
        @(negedge clk);
        key_in = 8'h00;

        wait (rec_kind.size() == 0);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cpu_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_assertions
    import isa_pkg::*;
    import bus_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      rd,
    input logic      wr,
    input ct_e       ct,
    input int_bits_t int_flags_in,
    input int_bits_t int_flags_out
);

    ////////////////////////////////////////
    // Bus strobes
    ////////////////////////////////////////
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst) !(rd && wr))
        else $error("rd and wr high together");

    rd_window: assert property (@(posedge clk) disable iff (rst) rd |-> (ct == T1 || ct == T2))
        else $error("rd outside T1/T2");

    wr_window: assert property (@(posedge clk) disable iff (rst) wr |-> (ct == T3))
        else $error("wr outside T3");

    // Flag clear removes at most one bit, never adds
    flag_clear: assert property (@(posedge clk) disable iff (rst)
        ((int_flags_out & ~int_flags_in) == '0) &&
        ($countones(int_flags_out ^ int_flags_in) <= 1))
        else $error("int_flags_out not a single clear of int_flags_in");

endmodule

bind cpu_top cpu_assertions u_cpu_assertions (
    .clk           (clk),
    .rst           (rst),
    .rd            (rd),
    .wr            (wr),
    .ct            (ct),
    .int_flags_in  (int_flags_in),
    .int_flags_out (int_flags_out)
);

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  data_t     din,
    input  int_bits_t int_en,
    input  int_bits_t int_flags_in,
    input  data_t     key_in,
    output logic      phi,
    output logic      rd,
    output logic      wr,
    output logic      done,
    output ct_e       ct,
    output addr_t     a,
    output data_t     dout,
    output int_bits_t int_flags_out
);

    bus_op_e bus_op;
    ab_src_e ab_src;
    db_src_e db_src;
    addr_t   pc;
    addr_t   sp;
    addr_t   vector;
    data_t   opcode;
    logic    inc;
    logic    revert;
    logic    int_ack;
    logic    int_req;
    logic    wake;
    logic    ime;
    logic    halted;
    logic    stopped;

    ////////////////////////////////////////
    // Machine-cycle engine
    ////////////////////////////////////////
    bus_cycle_ctrl u_bus_cycle_ctrl (
        .clk    (clk),
        .rst    (rst),
        .bus_op (bus_op),
        .ab_src (ab_src),
        .db_src (db_src),
        .pc     (pc),
        .sp     (sp),
        .din    (din),
        .ct     (ct),
        .phi    (phi),
        .rd     (rd),
        .wr     (wr),
        .a      (a),
        .dout   (dout),
        .opcode (opcode)
    );

    pc_unit u_pc_unit (
        .clk     (clk),
        .rst     (rst),
        .ct      (ct),
        .inc     (inc),
        .revert  (revert),
        .int_ack (int_ack),
        .vector  (vector),
        .pc      (pc)
    );

    // Interrupts and wake
    int_unit u_int_unit (
        .clk           (clk),
        .rst           (rst),
        .ct            (ct),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .key_in        (key_in),
        .ime           (ime),
        .halted        (halted),
        .stopped       (stopped),
        .int_ack       (int_ack),
        .int_req       (int_req),
        .wake          (wake),
        .vector        (vector),
        .int_flags_out (int_flags_out)
    );

    exec_fsm u_exec_fsm (
        .clk     (clk),
        .rst     (rst),
        .ct      (ct),
        .opcode  (opcode),
        .int_req (int_req),
        .wake    (wake),
        .bus_op  (bus_op),
        .ab_src  (ab_src),
        .db_src  (db_src),
        .sp      (sp),
        .inc     (inc),
        .revert  (revert),
        .int_ack (int_ack),
        .ime     (ime),
        .halted  (halted),
        .stopped (stopped),
        .done    (done)
    );

endmodule

`default_nettype wire

//--- rtl/exec_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module exec_fsm
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ct_e     ct,
    input  data_t   opcode,
    input  logic    int_req,
    input  logic    wake,
    output bus_op_e bus_op,
    output ab_src_e ab_src,
    output db_src_e db_src,
    output addr_t   sp,
    output logic    inc,
    output logic    revert,
    output logic    int_ack,
    output logic    ime,
    output logic    halted,
    output logic    stopped,
    output logic    done
);

    typedef enum logic [2:0] {
        EX_FETCH,
        EX_HALT,
        EX_STOP,
        EX_INT0,
        EX_INT1,
        EX_INT2,
        EX_INT3,
        EX_INT4
    } ex_state_e;

    ex_state_e state;
    ex_state_e state_next;
    logic      int_pending;  // Dispatch decision taken at T2
    logic      from_fetch;   // Dispatch cut a fetch short

    ////////////////////////////////////////
    // Next machine cycle
    ////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            EX_FETCH: begin
                if (int_pending) begin
                    state_next = EX_INT0;   // Fetched byte is dropped
                end else if (opcode == OP_HALT) begin
                    state_next = EX_HALT;
                end else if (opcode == OP_STOP) begin
                    state_next = EX_STOP;
                end
            end
            EX_HALT: begin
                if (int_pending) begin
                    state_next = EX_INT0;
                end else if (wake) begin
                    state_next = EX_FETCH;
                end
            end
            EX_STOP: if (wake) state_next = EX_FETCH;
            EX_INT0: state_next = EX_INT1;
            EX_INT1: state_next = EX_INT2;
            EX_INT2: state_next = EX_INT3;
            EX_INT3: state_next = EX_INT4;
            EX_INT4: state_next = EX_FETCH;
            default: state_next = EX_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= EX_FETCH;
            int_pending <= 1'b0;
            from_fetch  <= 1'b0;
            ime         <= 1'b0;
            sp          <= SP_RESET;
            done        <= 1'b0;
        end else begin
            done <= halted | stopped;
            if (ct == T2 && (state == EX_FETCH || state == EX_HALT)) begin
                int_pending <= int_req;
            end
            if (ct == T3) begin
                state <= state_next;
                if (state_next == EX_INT0) begin
                    from_fetch <= (state == EX_FETCH);
                end
                // DI and EI act at once
                if (state == EX_FETCH && !int_pending) begin
                    if (opcode == OP_DI) ime <= 1'b0;
                    if (opcode == OP_EI) ime <= 1'b1;
                end
                if (state == EX_INT2 || state == EX_INT3) begin
                    sp <= sp - 16'd1;
                end
                if (state == EX_INT4) ime <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Per-cycle controls
    ////////////////////////////////////////
    always_comb begin
        bus_op = BUS_IDLE;
        ab_src = AB_PC;
        db_src = DB_PC_LOW;
        case (state)
            EX_FETCH: bus_op = BUS_FETCH;
            EX_INT2: begin
                bus_op = BUS_WRITE;
                ab_src = AB_SP;
                db_src = DB_PC_HIGH;  // High byte goes first
            end
            EX_INT3: begin
                bus_op = BUS_WRITE;
                ab_src = AB_SP;
            end
            default: begin
            end
        endcase
    end

    assign inc     = (state == EX_FETCH);
    assign revert  = (state == EX_INT0) && from_fetch;
    assign int_ack = (state == EX_INT4) && (ct == T3);  // One clock only
    assign halted  = (state == EX_HALT);
    assign stopped = (state == EX_STOP);

endmodule

`default_nettype wire

//--- rtl/int_unit.sv
`timescale 1ns/100ps
`default_nettype none

module int_unit
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  ct_e       ct,
    input  int_bits_t int_en,
    input  int_bits_t int_flags_in,
    input  data_t     key_in,
    input  logic      ime,
    input  logic      halted,
    input  logic      stopped,
    input  logic      int_ack,
    output logic      int_req,
    output logic      wake,
    output addr_t     vector,
    output int_bits_t int_flags_out
);

    int_bits_t            pending;   // Enabled, ignoring IME
    int_bits_t            masked;
    int_bits_t            pri_hot;
    logic [INT_IDX_W-1:0] pri_idx;
    logic                 wake_cond;
    logic                 wake_delay;

    assign pending = int_flags_in & int_en;
    assign masked  = pending & {INT_W{ime}};
    assign int_req = |masked;

    ////////////////////////////////////////
    // Fixed priority, lowest bit first
    ////////////////////////////////////////
    always_comb begin
        pri_idx = '0;
        pri_hot = '0;
        for (int i = INT_W - 1; i >= 0; i--) begin
            if (masked[i]) begin
                pri_idx = INT_IDX_W'(i);
                pri_hot = int_bits_t'(1) << i;
            end
        end
    end

    // Nothing left at the jump sends the core to 0x0000
    assign vector = int_req ? addr_t'(INT_VEC_BASE + INT_VEC_STEP * addr_t'(pri_idx)) : '0;

    assign int_flags_out = int_ack ? (int_flags_in & ~pri_hot) : int_flags_in;

    // HALT wakes on any enabled flag, STOP also on a key
    assign wake_cond = (halted && (pending != '0)) ||
                       (stopped && ((pending != '0) || (key_in != '0)));

    // Wake held back one machine cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wake_delay <= 1'b0;
            wake       <= 1'b0;
        end else if (ct == T2) begin
            wake_delay <= wake_cond;
            wake       <= wake_delay;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pc_unit.sv
`timescale 1ns/100ps
`default_nettype none

module pc_unit
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  ct_e   ct,
    input  logic  inc,
    input  logic  revert,
    input  logic  int_ack,
    input  addr_t vector,
    output addr_t pc
);

    addr_t      saved_pc;  // Copy taken when a fetch starts incrementing
    logic       carry;
    logic [8:0] lo_sum;

    // Low byte step, the carry goes into the high byte one clock later
    assign lo_sum = {1'b0, pc[7:0]} + 9'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= PC_RESET;
            carry <= 1'b0;
        end else begin
            case (ct)
                T1: begin
                    if (inc) begin
                        pc[7:0] <= lo_sum[7:0];
                        carry   <= lo_sum[8];
                    end
                end
                T2: begin
                    if (inc) begin
                        pc[15:8] <= pc[15:8] + {7'b0, carry};
                    end
                end
                T3: begin
                    if (revert) begin
                        pc <= saved_pc;     // Undo the discarded fetch
                    end else if (int_ack) begin
                        pc <= vector;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ct == T1 && inc) begin
            saved_pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bus_cycle_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module bus_cycle_ctrl
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  bus_op_e bus_op,
    input  ab_src_e ab_src,
    input  db_src_e db_src,
    input  addr_t   pc,
    input  addr_t   sp,
    input  data_t   din,
    output ct_e     ct,
    output logic    phi,
    output logic    rd,
    output logic    wr,
    output addr_t   a,
    output data_t   dout,
    output data_t   opcode
);

    addr_t ab_sel;
    data_t db_sel;

    // Pushes pre-decrement, so the SP source points one below
    assign ab_sel = (ab_src == AB_SP) ? addr_t'(sp - 16'd1) : pc;
    assign db_sel = (db_src == DB_PC_HIGH) ? pc[15:8] : pc[7:0];

    ////////////////////////////////////////
    // T-cycle counter
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ct <= T0;
        end else begin
            ct <= ct_e'(ct + 2'd1);  // Free running, wraps T3 -> T0
        end
    end

    ////////////////////////////////////////
    // Registered bus outputs
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            a    <= '0;
            rd   <= 1'b0;
            wr   <= 1'b0;
            phi  <= 1'b1;
            dout <= '0;
        end else begin
            case (ct)
                T0: begin
                    // Address setup, strobe valid in T1/T2
                    a   <= ab_sel;
                    rd  <= (bus_op == BUS_FETCH);
                    wr  <= 1'b0;
                    phi <= 1'b1;
                end
                T1: begin
                    // Read in progress
                end
                T2: begin
                    if (bus_op == BUS_WRITE) begin
                        wr   <= 1'b1;
                        dout <= db_sel;
                    end
                    rd  <= 1'b0;
                    phi <= 1'b0;
                end
                T3: begin
                    rd   <= 1'b0;
                    wr   <= 1'b0;
                    dout <= '0;      // Bus idle
                end
                default: begin
                end
            endcase
        end
    end

    // Opcode latch, memory answers din combinationally by end of T2
    always_ff @(posedge clk) begin
        if (ct == T2 && bus_op == BUS_FETCH) begin
            opcode <= din;
        end
    end

endmodule

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // T-cycle phase, four per machine cycle
    typedef enum logic [1:0] {
        T0 = 2'b00,
        T1 = 2'b01,
        T2 = 2'b10,
        T3 = 2'b11
    } ct_e;

    // Kind of bus access in the current machine cycle
    typedef enum logic [1:0] {
        BUS_IDLE  = 2'b00,
        BUS_FETCH = 2'b01,
        BUS_WRITE = 2'b10
    } bus_op_e;

    typedef enum logic {
        AB_PC = 1'b0,
        AB_SP = 1'b1   // Push address, SP - 1
    } ab_src_e;

    typedef enum logic {
        DB_PC_HIGH = 1'b0,
        DB_PC_LOW  = 1'b1
    } db_src_e;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    ////////////////////////////////////////
    // Architectural widths
    ////////////////////////////////////////
    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 8;
    localparam int INT_W     = 5;  // VBlank, LCD, timer, serial, joypad
    localparam int INT_IDX_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [INT_W-1:0]  int_bits_t;  // Bit 0 wins priority

    ////////////////////////////////////////
    // Decoded opcodes
    ////////////////////////////////////////
    localparam data_t OP_HALT = 8'h76;
    localparam data_t OP_STOP = 8'h10;  // Treated as one byte
    localparam data_t OP_DI   = 8'hF3;
    localparam data_t OP_EI   = 8'hFB;

    // Interrupt i jumps to base + i * step
    localparam addr_t INT_VEC_BASE = 16'h0040;
    localparam addr_t INT_VEC_STEP = 16'd8;

    ////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////
    localparam addr_t SP_RESET = 16'hFFFE;
    localparam addr_t PC_RESET = 16'h0000;

endpackage

`default_nettype wire
